// File: rx_params.svh
`ifndef RX_PARAMS_SVH
`define RX_PARAMS_SVH

// Packet FIFO depth is 2**RX_FIFO_AW entries
`define RX_FIFO_AW 5

// CRC-16 preset at the start of each packet
`define RX_CRC_SEED 16'hFFFF

`endif

// File: serdes_codes_pkg.sv
package serdes_codes_pkg;

   // 8b/10b control characters, used with the K flag set
   localparam logic [7:0] K_COMMA     = 8'b101_11100;  // K28.5
   localparam logic [7:0] K_IDLE      = 8'b001_11100;  // K28.1
   localparam logic [7:0] K_PKT_START = 8'b110_11100;  // K28.6
   localparam logic [7:0] K_PKT_END   = 8'b100_11100;  // K28.4
   localparam logic [7:0] K_XON       = 8'b010_11100;  // K28.2
   localparam logic [7:0] K_XOFF      = 8'b011_11100;  // K28.3
   localparam logic [7:0] K_ERROR     = 8'b000_00000;  // K0.0, sent when the far end sees errors
   localparam logic [7:0] D_56        = 8'b110_00101;  // D5.6, paired with the comma

   // Byte view for control character matching
   typedef struct packed {
      logic       k_msb;
      logic       k_lsb;
      logic [7:0] hi;
      logic [7:0] lo;
   } serdes_pair_t;

   // Half-line view for payload and CRC
   typedef struct packed {
      logic        k_msb;
      logic        k_lsb;
      logic [15:0] data;
   } serdes_half_t;

   typedef union packed {
      serdes_pair_t pair;
      serdes_half_t half;
   } serdes_word_u;

endpackage

// File: rx_buf_pkg.sv
package rx_buf_pkg;

   // One FIFO entry, flags above the line
   typedef struct packed {
      logic        error;
      logic        sop;
      logic        eop;
      logic [31:0] line;
   } rx_entry_t;

   typedef enum logic [2:0] {
      IDLE,
      FIRST_LO,
      FIRST_HI,
      PKT_LO,     // Last line still held here until the next word decides
      PKT_HI,
      CRC_CHECK,
      ERROR,
      DONE
   } framer_state_e;

endpackage

// File: rx_line_if.sv
interface rx_line_if;
   import rx_buf_pkg::*;

   rx_entry_t entry;
   logic      write;
   logic      full;

   // Framer side
   modport writer (
      output entry,
      output write,
      input  full
   );

   // FIFO side
   modport store (
      input  entry,
      input  write,
      output full
   );

endinterface

// File: rx_lane_align.sv
module rx_lane_align (
   input  logic                           ser_rx_clk,
   input  logic                           rst_rxclk,
   input  logic [15:0]                    ser_r_i,
   input  logic                           ser_rklsb_i,
   input  logic                           ser_rkmsb_i,
   output serdes_codes_pkg::serdes_word_u word_o,
   output logic                           sop_seen_o,
   output logic                           wait_o,
   output logic                           xon_rcvd_o,
   output logic                           xoff_rcvd_o,
   output logic                           link_up_o
);
   import serdes_codes_pkg::*;

   localparam logic [17:0] START_PAIR = {2'b11, K_PKT_START, K_PKT_START};
   localparam logic [17:0] COMMA_WORD = {2'b10, K_COMMA, D_56};
   localparam logic [17:0] XON_PAIR   = {2'b11, K_XON, K_XON};
   localparam logic [17:0] XOFF_PAIR  = {2'b11, K_XOFF, K_XOFF};
   localparam logic [17:0] ERR_PAIR   = {2'b11, K_ERROR, K_ERROR};

   serdes_word_u even_w;
   serdes_word_u odd_w;
   serdes_word_u chosen_w;
   logic [7:0]   hold_byte;    // High byte of the previous word
   logic         hold_k;
   logic         odd_q;        // Phase of the last start pair
   logic         odd_nxt;
   logic         start_even;
   logic         start_odd;
   logic         is_wait;
   logic         link_ok;
   logic [1:0]   link_hist;

   always_comb
   begin
      even_w     = {ser_rkmsb_i, ser_rklsb_i, ser_r_i};
      odd_w      = {ser_rklsb_i, hold_k, ser_r_i[7:0], hold_byte};  // Straddles two words
      start_even = (even_w.pair == START_PAIR);
      start_odd  = (odd_w.pair == START_PAIR);
      odd_nxt    = start_even ? 1'b0 : (start_odd ? 1'b1 : odd_q);
      chosen_w   = odd_nxt ? odd_w : even_w;
      // Far end is flow controlled or asking us to pause
      is_wait    = (chosen_w.pair == COMMA_WORD) || (chosen_w.pair == XON_PAIR) ||
                   (chosen_w.pair == XOFF_PAIR);
      link_ok    = (even_w.pair != ERR_PAIR);
   end

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         hold_byte   <= 8'h00;
         hold_k      <= 1'b0;
         odd_q       <= 1'b0;
         sop_seen_o  <= 1'b0;
         wait_o      <= 1'b0;
         xon_rcvd_o  <= 1'b0;
         xoff_rcvd_o <= 1'b0;
         link_hist   <= 2'b00;
         link_up_o   <= 1'b0;
      end
      else
      begin
         hold_byte   <= even_w.pair.hi;
         hold_k      <= even_w.pair.k_msb;
         odd_q       <= odd_nxt;
         sop_seen_o  <= start_even | start_odd;
         wait_o      <= is_wait;
         // Either byte lane may carry the character
         xon_rcvd_o  <= (even_w.pair.k_msb && even_w.pair.hi == K_XON) ||
                        (even_w.pair.k_lsb && even_w.pair.lo == K_XON);
         xoff_rcvd_o <= (even_w.pair.k_msb && even_w.pair.hi == K_XOFF) ||
                        (even_w.pair.k_lsb && even_w.pair.lo == K_XOFF);
         link_hist   <= {link_hist[0], link_ok};
         link_up_o   <= link_ok & (&link_hist);  // Three good words in a row
      end
   end

   always_ff @(posedge ser_rx_clk)
   begin
      word_o <= chosen_w;
   end

endmodule

// File: rx_framer.sv
`include "rx_params.svh"

module rx_framer (
   input  logic                           ser_rx_clk,
   input  logic                           rst_rxclk,
   input  serdes_codes_pkg::serdes_word_u word_i,
   input  logic                           sop_seen_i,
   input  logic                           wait_i,
   rx_line_if.writer                      line_if
);
   import serdes_codes_pkg::*;
   import rx_buf_pkg::*;

   localparam logic [17:0] END_PAIR = {2'b11, K_PKT_END, K_PKT_END};
   localparam logic [15:0] CRC_POLY = 16'h1021;  // CCITT

   framer_state_e state;
   logic [15:0]   half_q;     // Low half waiting for its partner
   logic [31:0]   line_q;
   logic          sop_q;
   logic          eop_q;
   logic          err_q;
   logic          wr_q;
   logic [15:0]   crc_q;
   logic [15:0]   crc_nxt;
   logic          is_data;
   logic          is_end;

   // One 16-bit half folded in, MSB first
   function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [15:0] din);
      logic [15:0] c;
      logic        fb;
      c = crc;
      for (int i = 15; i >= 0; i--)
      begin
         fb = c[15] ^ din[i];
         c  = {c[14:0], 1'b0} ^ (fb ? CRC_POLY : 16'h0000);
      end
      return c;
   endfunction

   assign is_data = ~word_i.half.k_msb & ~word_i.half.k_lsb;
   assign is_end  = (word_i.pair == END_PAIR);
   assign crc_nxt = crc16_step(crc_q, word_i.half.data);

   assign line_if.write = wr_q;
   assign line_if.entry = {err_q, sop_q, eop_q, line_q};

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         state <= IDLE;
         sop_q <= 1'b0;
         eop_q <= 1'b0;
         err_q <= 1'b0;
         wr_q  <= 1'b0;
      end
      else
      begin
         wr_q  <= 1'b0;
         eop_q <= 1'b0;
         err_q <= 1'b0;
         if (wr_q)
            sop_q <= 1'b0;  // First line is out
         case (state)
            IDLE:
               if (sop_seen_i)
               begin
                  sop_q <= 1'b1;
                  state <= FIRST_LO;
               end
            FIRST_LO, PKT_HI, FIRST_HI:
               if (is_data)
                  state <= (state == FIRST_LO) ? FIRST_HI : PKT_LO;
               else if (!wait_i)
                  state <= ERROR;
            PKT_LO:
               if (is_data)
               begin
                  // Held line is not the last one, so write it now
                  if (line_if.full)
                     state <= ERROR;
                  else
                  begin
                     wr_q  <= 1'b1;
                     state <= PKT_HI;
                  end
               end
               else if (is_end)
                  state <= CRC_CHECK;
               else if (!wait_i)
                  state <= ERROR;
            CRC_CHECK:
               if (is_data && word_i.half.data == crc_q && !line_if.full)
               begin
                  wr_q  <= 1'b1;   // Held line goes out as eop
                  eop_q <= 1'b1;
                  state <= DONE;
               end
               else if (!wait_i)
                  state <= ERROR;
            ERROR:
               if (!line_if.full)
               begin
                  wr_q  <= 1'b1;
                  err_q <= 1'b1;
                  state <= IDLE;
               end
            DONE:
               state <= IDLE;
            default:
               state <= IDLE;
         endcase
      end
   end

   // Line assembly
   always_ff @(posedge ser_rx_clk)
   begin
      if (is_data && (state == FIRST_LO || state == PKT_LO))
         half_q <= word_i.half.data;
      if (is_data && (state == FIRST_HI || state == PKT_HI))
         line_q <= {word_i.half.data, half_q};
   end

   // Running CRC, the CRC word itself is compared before it is folded in
   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk || state == IDLE)
         crc_q <= `RX_CRC_SEED;
      else if (is_data)
         crc_q <= crc_nxt;
   end

endmodule

// File: rx_pkt_fifo.sv
`include "rx_params.svh"

module rx_pkt_fifo #(
   parameter int AW = `RX_FIFO_AW
) (
   input  logic                  ser_rx_clk,
   input  logic                  rst_rxclk,
   rx_line_if.store              line_if,
   input  logic                  read_i,
   output rx_buf_pkg::rx_entry_t head_o,
   output logic                  empty_o,
   output logic [15:0]           space_o
);
   import rx_buf_pkg::*;

   localparam int DEPTH = 1 << AW;

   rx_entry_t   mem [DEPTH];
   logic [AW:0] wr_ptr;        // Extra bit tells full from empty
   logic [AW:0] rd_ptr;
   logic [AW:0] used;
   logic        do_wr;
   logic        do_rd;

   assign used         = wr_ptr - rd_ptr;
   assign empty_o      = (used == '0);
   assign line_if.full = used[AW];
   assign space_o      = 16'(DEPTH) - 16'(used);
   assign head_o       = mem[rd_ptr[AW-1:0]];
   assign do_wr        = line_if.write & ~line_if.full;
   assign do_rd        = read_i & ~empty_o;

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge ser_rx_clk)
   begin
      if (do_wr)
         mem[wr_ptr[AW-1:0]] <= line_if.entry;
   end

endmodule

// File: rx_pkt_drain.sv
module rx_pkt_drain (
   input  logic                  ser_rx_clk,
   input  logic                  rst_rxclk,
   input  rx_buf_pkg::rx_entry_t head_i,
   input  logic                  empty_i,
   input  logic                  wr_ready_i,
   input  logic                  wr_full_i,
   output logic                  read_o,
   output logic [31:0]           wr_dat_o,
   output logic                  wr_write_o,
   output logic                  wr_done_o,
   output logic                  wr_error_o
);
   logic xfer_q;   // Packet in progress towards the buffer

   always_ff @(posedge ser_rx_clk)
   begin
      if (rst_rxclk)
         xfer_q <= 1'b0;
      else if (xfer_q && !empty_i && (head_i.eop || head_i.error || wr_full_i))
         xfer_q <= 1'b0;
      else if (wr_ready_i && head_i.sop && !empty_i)
         xfer_q <= 1'b1;
   end

   assign read_o     = (xfer_q | ~head_i.sop) & ~empty_i;  // Stray lines just drop
   assign wr_write_o = xfer_q & ~empty_i;
   assign wr_done_o  = xfer_q & ~empty_i & head_i.eop;
   assign wr_error_o = xfer_q & ~empty_i & head_i.error;
   assign wr_dat_o   = head_i.line;

endmodule

// File: serdes_rx.sv
`include "rx_params.svh"

module serdes_rx (
   input  logic        ser_rx_clk,
   input  logic        rst_rxclk,
   input  logic [15:0] ser_r_i,
   input  logic        ser_rklsb_i,
   input  logic        ser_rkmsb_i,
   output logic [31:0] wr_dat_o,
   output logic        wr_write_o,
   output logic        wr_done_o,
   output logic        wr_error_o,
   input  logic        wr_ready_i,
   input  logic        wr_full_i,
   output logic [15:0] fifo_space_o,
   output logic        xon_rcvd_o,
   output logic        xoff_rcvd_o,
   output logic        link_up_o
);
   import serdes_codes_pkg::*;
   import rx_buf_pkg::*;

   serdes_word_u word;
   logic         sop_seen;
   logic         wait_word;
   rx_entry_t    head;
   logic         empty;
   logic         read;

   rx_line_if line_if ();

   rx_lane_align rx_lane_align_inst (
      .ser_rx_clk  (ser_rx_clk),
      .rst_rxclk   (rst_rxclk),
      .ser_r_i     (ser_r_i),
      .ser_rklsb_i (ser_rklsb_i),
      .ser_rkmsb_i (ser_rkmsb_i),
      .word_o      (word),
      .sop_seen_o  (sop_seen),
      .wait_o      (wait_word),
      .xon_rcvd_o  (xon_rcvd_o),
      .xoff_rcvd_o (xoff_rcvd_o),
      .link_up_o   (link_up_o)
   );

   rx_framer rx_framer_inst (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .word_i     (word),
      .sop_seen_i (sop_seen),
      .wait_i     (wait_word),
      .line_if    (line_if.writer)
   );

   rx_pkt_fifo #(.AW(`RX_FIFO_AW)) rx_pkt_fifo_inst (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .line_if    (line_if.store),
      .read_i     (read),
      .head_o     (head),
      .empty_o    (empty),
      .space_o    (fifo_space_o)
   );

   rx_pkt_drain rx_pkt_drain_inst (
      .ser_rx_clk (ser_rx_clk),
      .rst_rxclk  (rst_rxclk),
      .head_i     (head),
      .empty_i    (empty),
      .wr_ready_i (wr_ready_i),
      .wr_full_i  (wr_full_i),
      .read_o     (read),
      .wr_dat_o   (wr_dat_o),
      .wr_write_o (wr_write_o),
      .wr_done_o  (wr_done_o),
      .wr_error_o (wr_error_o)
   );

endmodule

// File: serdes_rx_sva.sv
module serdes_rx_sva (
   input logic                  ser_rx_clk,
   input logic                  rst_rxclk,
   input logic                  write_i,
   input logic                  done_i,
   input logic                  error_i,
   input logic                  read_i,
   input logic                  empty_i,
   input rx_buf_pkg::rx_entry_t head_i
);
   timeunit 1ns;
   timeprecision 1ps;

   // One entry never both closes and aborts a packet
   done_error_excl: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      !(done_i && error_i))
      else $error("wr_done_o and wr_error_o asserted together");

   // A sop line opens a transfer, it never lands inside one
   sop_opens_xfer: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      (write_i && head_i.sop) |-> !$past(write_i))
      else $error("sop line written in the middle of a transfer");

   // Head waits unchanged until the drain takes it
   head_held: assert property (@(posedge ser_rx_clk) disable iff (rst_rxclk)
      (!empty_i && !read_i) |=> (!empty_i && $stable(head_i)))
      else $error("FIFO head changed or emptied without a read");

endmodule

bind rx_pkt_drain serdes_rx_sva drain_sva_inst (
   .ser_rx_clk (ser_rx_clk),
   .rst_rxclk  (rst_rxclk),
   .write_i    (wr_write_o),
   .done_i     (wr_done_o),
   .error_i    (wr_error_o),
   .read_i     (read_o),
   .empty_i    (empty_i),
   .head_i     (head_i)
);

// File: tb_clkgen.sv
module tb_clkgen #(
   parameter int HALF_NS    = 2,
   parameter int RST_CYCLES = 4
) (
   output logic clk_o,
   output logic rst_o
);
   timeunit 1ns;
   timeprecision 1ps;

   initial
   begin
      clk_o = 1'b0;
      forever
         #(HALF_NS) clk_o = ~clk_o;   // 4 ns period
   end

   initial
   begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;   // Released away from the sampling edge
   end

endmodule

// File: tb_serdes_rx.sv
`include "rx_params.svh"

module tb_serdes_rx;
   timeunit 1ns;
   timeprecision 1ps;
   import serdes_codes_pkg::*;

   localparam int NT      = 5;
   localparam int DEPTH   = 1 << `RX_FIFO_AW;
   localparam int TIMEOUT = 400;   // Cycles allowed per wait loop

   logic        ser_rx_clk;
   logic        rst_rxclk;
   logic [15:0] ser_r;
   logic        ser_rklsb;
   logic        ser_rkmsb;
   logic        wr_ready;
   logic        wr_full;
   logic [31:0] wr_dat;
   logic        wr_write;
   logic        wr_done;
   logic        wr_error;
   logic [15:0] fifo_space;
   logic        xon_rcvd;
   logic        xoff_rcvd;
   logic        link_up;

   // Packet table, one row per test
   string       t_name [NT];
   bit          t_odd  [NT];
   int          t_nl   [NT];
   logic [31:0] t_line [NT][4];
   bit          t_bad  [NT];
   int          t_xon  [NT];   // Half index that gets an XON pair before it, -1 none
   int          t_xoff [NT];
   bit          t_hold [NT];   // wr_ready low until the packet sits in the FIFO

   logic [8:0]  stream [$];    // {K flag, byte}, low byte first
   logic [31:0] got_line [$];
   logic        got_done [$];
   logic        got_err  [$];
   int          end_cnt    = 0;
   int          xon_cnt    = 0;
   int          xoff_cnt   = 0;
   int          jump_cnt   = 0;
   logic [15:0] space_prev = 16'(DEPTH);
   int          err_cnt;
   int          pass_cnt;
   int          fail_cnt;
   bit          timed_out;
   integer      seed = 32'h2b09_162e;

   tb_clkgen clkgen_inst (.clk_o(ser_rx_clk), .rst_o(rst_rxclk));

   serdes_rx serdes_rx_inst (
      .ser_rx_clk   (ser_rx_clk),
      .rst_rxclk    (rst_rxclk),
      .ser_r_i      (ser_r),
      .ser_rklsb_i  (ser_rklsb),
      .ser_rkmsb_i  (ser_rkmsb),
      .wr_dat_o     (wr_dat),
      .wr_write_o   (wr_write),
      .wr_done_o    (wr_done),
      .wr_error_o   (wr_error),
      .wr_ready_i   (wr_ready),
      .wr_full_i    (wr_full),
      .fifo_space_o (fifo_space),
      .xon_rcvd_o   (xon_rcvd),
      .xoff_rcvd_o  (xoff_rcvd),
      .link_up_o    (link_up)
   );

   // Capture of the buffer side, mid-cycle
   always @(negedge ser_rx_clk)
   begin
      if (!rst_rxclk)
      begin
         if (wr_write)
         begin
            got_line.push_back(wr_dat);
            got_done.push_back(wr_done);
            got_err.push_back(wr_error);
            if (wr_done || wr_error)
               end_cnt++;
         end
         if (xon_rcvd)
            xon_cnt++;
         if (xoff_rcvd)
            xoff_cnt++;
         if (fifo_space < space_prev && space_prev - fifo_space != 16'd1)
            jump_cnt++;   // More than one slot taken in a cycle
         space_prev = fifo_space;
      end
   end

   // CCITT CRC-16 over one byte, MSB first
   function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] b);
      logic [15:0] r;
      r = crc ^ {b, 8'h00};
      for (int i = 0; i < 8; i++)
         r = r[15] ? ((r << 1) ^ 16'h1021) : (r << 1);
      return r;
   endfunction

   function automatic logic [15:0] row_half(input int r, input int i);
      return i[0] ? t_line[r][i / 2][31:16] : t_line[r][i / 2][15:0];
   endfunction

   function automatic logic [15:0] row_crc(input int r);
      logic [15:0] c;
      logic [15:0] h;
      c = `RX_CRC_SEED;
      for (int i = 0; i < 2 * t_nl[r]; i++)
      begin
         h = row_half(r, i);
         c = crc_byte(c, h[15:8]);   // Half is folded high byte first
         c = crc_byte(c, h[7:0]);
      end
      return c;
   endfunction

   task automatic report_mismatch(input string test, input string what,
                                  input logic [31:0] exp, input logic [31:0] act);
      $display("CHECK FAILED %s: %s expected %h actual %h", test, what, exp, act);
      err_cnt++;
   endtask

   task automatic set_row(input int r, input string name, input bit odd, input int nl,
                          input logic [31:0] l0, input logic [31:0] l1,
                          input logic [31:0] l2, input logic [31:0] l3,
                          input bit bad, input int xon, input int xoff, input bit hold);
      t_name[r]    = name;
      t_odd[r]     = odd;
      t_nl[r]      = nl;
      t_line[r][0] = l0;
      t_line[r][1] = l1;
      t_line[r][2] = l2;
      t_line[r][3] = l3;
      t_bad[r]     = bad;
      t_xon[r]     = xon;
      t_xoff[r]    = xoff;
      t_hold[r]    = hold;
   endtask

   task automatic load_table();
      set_row(0, "even_good", 1'b0, 3, 32'h1122_3344, 32'h5566_7788, 32'h99aa_bbcc,
              32'h0, 1'b0, -1, -1, 1'b0);
      set_row(1, "odd_good", 1'b1, 3, 32'h1122_3344, 32'h5566_7788, 32'h99aa_bbcc,
              32'h0, 1'b0, -1, -1, 1'b0);
      set_row(2, "bad_crc", 1'b0, 2, 32'hdead_beef, 32'h0bad_f00d, 32'h0, 32'h0,
              1'b1, -1, -1, 1'b0);
      set_row(3, "flow_ctrl", 1'b0, 4, 32'h0102_0304, 32'ha5a5_5a5a, 32'hffff_0000,
              32'h1357_9bdf, 1'b0, 1, 4, 1'b0);
      set_row(4, "ready_hold", 1'b0, 3, 32'hcafe_0001, 32'hcafe_0002, 32'hcafe_0003,
              32'h0, 1'b0, -1, -1, 1'b1);
   endtask

   task automatic push_k_pair(input logic [7:0] code);
      stream.push_back({1'b1, code});
      stream.push_back({1'b1, code});
   endtask

   task automatic build_stream(input int r);
      logic [15:0] h;
      logic [15:0] crc;
      stream.delete();
      if (t_odd[r])
         stream.push_back({1'b1, K_IDLE});   // One byte shifts the pair phase
      push_k_pair(K_PKT_START);
      for (int i = 0; i < 2 * t_nl[r]; i++)
      begin
         if (i == t_xon[r])
            push_k_pair(K_XON);
         if (i == t_xoff[r])
            push_k_pair(K_XOFF);
         h = row_half(r, i);
         stream.push_back({1'b0, h[7:0]});
         stream.push_back({1'b0, h[15:8]});
      end
      push_k_pair(K_PKT_END);
      crc = row_crc(r) ^ (t_bad[r] ? 16'h0100 : 16'h0000);
      stream.push_back({1'b0, crc[7:0]});
      stream.push_back({1'b0, crc[15:8]});
      if (stream.size() % 2 != 0)
         stream.push_back({1'b1, K_IDLE});
   endtask

   task automatic send_stream();
      for (int i = 0; i < stream.size() / 2; i++)
      begin
         @(negedge ser_rx_clk);
         ser_r     = {stream[2 * i + 1][7:0], stream[2 * i][7:0]};
         ser_rkmsb = stream[2 * i + 1][8];
         ser_rklsb = stream[2 * i][8];
      end
   endtask

   task automatic send_idle(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(negedge ser_rx_clk);
         ser_r     = {K_IDLE, K_IDLE};
         ser_rkmsb = 1'b1;
         ser_rklsb = 1'b1;
      end
   endtask

   task automatic run_row(input int r);
      int          base;
      int          ends0;
      int          xon0;
      int          xoff0;
      int          jumps0;
      int          errs0;
      int          t;
      logic [15:0] exp_space;
      logic        exp_done;
      logic        exp_err;
      base   = got_line.size();
      ends0  = end_cnt;
      xon0   = xon_cnt;
      xoff0  = xoff_cnt;
      jumps0 = jump_cnt;
      errs0  = err_cnt;
      @(negedge ser_rx_clk);
      wr_ready = ~t_hold[r];
      if (t_hold[r] && fifo_space != 16'(DEPTH))
         report_mismatch(t_name[r], "space before packet", 32'(DEPTH), {16'h0, fifo_space});
      build_stream(r);
      send_stream();
      send_idle(($random(seed) & 3) + 2);
      if (t_hold[r])
      begin
         exp_space = 16'(DEPTH - t_nl[r]);
         t = 0;
         while (fifo_space != exp_space && t < TIMEOUT)
         begin
            @(negedge ser_rx_clk);
            t++;
         end
         if (fifo_space != exp_space)
            report_mismatch(t_name[r], "space with packet held", {16'h0, exp_space},
                            {16'h0, fifo_space});
         if (got_line.size() != base)
            report_mismatch(t_name[r], "lines while not ready", 0, got_line.size() - base);
         if (jump_cnt != jumps0)
            report_mismatch(t_name[r], "space steps over one", 0, jump_cnt - jumps0);
         @(negedge ser_rx_clk);
         wr_ready = 1'b1;
      end
      t = 0;
      while (end_cnt == ends0 && t < TIMEOUT)
      begin
         @(posedge ser_rx_clk);
         t++;
      end
      if (end_cnt == ends0)
      begin
         $display("ERROR: %s never ended with wr_done_o or wr_error_o", t_name[r]);
         timed_out = 1'b1;
         fail_cnt++;
         return;
      end
      if (got_line.size() - base != t_nl[r])
         report_mismatch(t_name[r], "entry count", t_nl[r], got_line.size() - base);
      else
         for (int i = 0; i < t_nl[r]; i++)
         begin
            exp_done = !t_bad[r] && (i == t_nl[r] - 1);
            exp_err  = t_bad[r] && (i == t_nl[r] - 1);
            if (got_line[base + i] !== t_line[r][i])
               report_mismatch(t_name[r], "line", t_line[r][i], got_line[base + i]);
            if (got_done[base + i] !== exp_done)
               report_mismatch(t_name[r], "done flag", {31'd0, exp_done},
                               {31'd0, got_done[base + i]});
            if (got_err[base + i] !== exp_err)
               report_mismatch(t_name[r], "error flag", {31'd0, exp_err},
                               {31'd0, got_err[base + i]});
         end
      if (xon_cnt - xon0 != (t_xon[r] >= 0 ? 1 : 0))
         report_mismatch(t_name[r], "xon pulses", (t_xon[r] >= 0 ? 1 : 0), xon_cnt - xon0);
      if (xoff_cnt - xoff0 != (t_xoff[r] >= 0 ? 1 : 0))
         report_mismatch(t_name[r], "xoff pulses", (t_xoff[r] >= 0 ? 1 : 0),
                         xoff_cnt - xoff0);
      if (err_cnt == errs0)
      begin
         pass_cnt++;
         $display("PASS %s", t_name[r]);
      end
      else
      begin
         fail_cnt++;
         $display("FAIL %s", t_name[r]);
      end
   endtask

   task automatic check_link_recovery();
      int errs0;
      int t;
      errs0 = err_cnt;
      if (link_up !== 1'b1)
         report_mismatch("link_error", "link_up before K0.0", 1, {31'd0, link_up});
      @(negedge ser_rx_clk);
      ser_r     = {K_ERROR, K_ERROR};
      ser_rkmsb = 1'b1;
      ser_rklsb = 1'b1;
      t = 0;
      while (link_up !== 1'b0 && t < 2)   // Must drop within two cycles
      begin
         @(negedge ser_rx_clk);
         t++;
      end
      if (link_up !== 1'b0)
         report_mismatch("link_error", "link_up after K0.0", 0, {31'd0, link_up});
      repeat (3) @(negedge ser_rx_clk);
      send_idle(1);
      repeat (2) @(negedge ser_rx_clk);
      if (link_up !== 1'b0)
         report_mismatch("link_error", "link_up after two good words", 0, {31'd0, link_up});
      @(negedge ser_rx_clk);
      if (link_up !== 1'b1)
         report_mismatch("link_error", "link_up after three good words", 1,
                         {31'd0, link_up});
      if (err_cnt == errs0)
      begin
         pass_cnt++;
         $display("PASS link_error");
      end
      else
      begin
         fail_cnt++;
         $display("FAIL link_error");
      end
   endtask

   initial
   begin
      int t;
      ser_r     = {K_IDLE, K_IDLE};
      ser_rkmsb = 1'b1;
      ser_rklsb = 1'b1;
      wr_ready  = 1'b1;
      wr_full   = 1'b0;
      err_cnt   = 0;
      pass_cnt  = 0;
      fail_cnt  = 0;
      timed_out = 1'b0;
      load_table();
      t = 0;
      while (rst_rxclk !== 1'b0 && t < 20)
      begin
         @(posedge ser_rx_clk);
         t++;
      end
      if (rst_rxclk !== 1'b0)
      begin
         $display("ERROR: reset was never released");
         timed_out = 1'b1;
      end
      else
      begin
         @(negedge ser_rx_clk);
         if ({wr_write, wr_done, wr_error, xon_rcvd, xoff_rcvd, link_up} !== 6'b0)
            report_mismatch("reset", "outputs after reset", 0,
                            {26'd0, wr_write, wr_done, wr_error, xon_rcvd, xoff_rcvd, link_up});
         send_idle(4);
      end
      for (int r = 0; r < NT && !timed_out; r++)
         run_row(r);
      if (!timed_out)
         check_link_recovery();
      $display("Tests passed %0d, failed %0d, check errors %0d", pass_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0 && fail_cnt == 0 && !timed_out)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: all.f
+incdir+.
serdes_codes_pkg.sv
rx_buf_pkg.sv
rx_line_if.sv
rx_lane_align.sv
rx_framer.sv
rx_pkt_fifo.sv
rx_pkt_drain.sv
serdes_rx.sv
serdes_rx_sva.sv
tb_clkgen.sv
tb_serdes_rx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then judge the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_serdes_rx \
   -f all.f -o tb_serdes_rx > build.log 2>&1 \
   && ./obj_dir/tb_serdes_rx > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "Compile or run error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation PASSED"
